/* tb/clear_stimulus.txt */
// columns in hex: test, trigger (0 reset, 1 a, 2 b, 3 both), a isolate ack delay,
// a clear ack delay, b isolate ack delay, b clear ack delay, a min/max, b min/max episodes
// reset with staggered release, both initiators run
01 00 01 01 01 01 01 02 01 02
// clear on a alone
02 01 01 02 01 02 01 01 01 01
// b isolate ack held back for ten cycles
03 01 02 01 0a 01 01 01 01 01
// a clear ack held back for twelve cycles
04 01 01 0c 01 01 01 01 01 01
// clear on both sides at once
05 03 01 01 01 01 01 02 01 02
// clear on b alone with uneven delays
06 02 03 00 02 04 01 01 01 01
// both sides again with zero and long delays mixed
07 03 00 05 04 00 01 02 01 02
// end marker
ff

/* verilog.f */
rtl/clear_seq_pkg.sv
rtl/phase_link_src.sv
rtl/phase_link_dst.sv
rtl/clear_initiator.sv
rtl/clear_receiver.sv
rtl/clear_ctrl_half.sv
rtl/cdc_clear_ctrl.sv
tb/clear_seq_sva.sv
tb/clear_seq_checker.sv
tb/tb_cdc_clear_ctrl.sv

/* tb/tb_cdc_clear_ctrl.sv */
// testbench for the clear-sequence controller
// two clocks, staggered resets, acknowledge models and file-driven test sequencing
`timescale 1ns/100ps
`default_nettype none

module tb_cdc_clear_ctrl;

  logic                     a_clk, b_clk;
  logic                     a_rst_n, b_rst_n;
  logic                     a_clear_req, a_iso_ack, a_clr_ack;
  logic                     b_clear_req, b_iso_ack, b_clr_ack;
  clear_seq_pkg::side_in_t  a_in, b_in;
  clear_seq_pkg::side_out_t a_out, b_out;
  // ten fields per test, see the header of the stimulus file
  logic [7:0]               stim_mem [0:79];
  logic [7:0]               a_iso_dly, a_clr_dly, b_iso_dly, b_clr_dly;
  int unsigned              a_iso_cnt, a_clr_cnt, b_iso_cnt, b_clr_cnt;

  // field order follows side_in_t, clear is the top bit
  assign a_in = {a_clear_req, a_iso_ack, a_clr_ack};
  assign b_in = {b_clear_req, b_iso_ack, b_clr_ack};

  cdc_clear_ctrl u_dut (
    .a_clk_i  (a_clk),
    .a_rst_ni (a_rst_n),
    .a_in_i   (a_in),
    .a_out_o  (a_out),
    .b_clk_i  (b_clk),
    .b_rst_ni (b_rst_n),
    .b_in_i   (b_in),
    .b_out_o  (b_out)
  );

  clear_seq_checker u_checker (
    .a_clk_i  (a_clk),
    .a_rst_ni (a_rst_n),
    .a_in_i   (a_in),
    .a_out_i  (a_out),
    .b_clk_i  (b_clk),
    .b_rst_ni (b_rst_n),
    .b_in_i   (b_in),
    .b_out_i  (b_out)
  );

  // ----------------------------------------------------------
  // clocks and acknowledge models
  // ----------------------------------------------------------

  // 4 ns on both sides, b trails a by 1.3 ns so the edges never coincide
  initial begin
    a_clk = 1'b0;
    forever #2 a_clk = ~a_clk;
  end

  initial begin
    b_clk = 1'b0;
    #1.3;
    forever #2 b_clk = ~b_clk;
  end

  // the ack follows its output after the given number of cycles and drops with it
  task automatic step_ack(input logic level, input logic [7:0] delay,
                          inout int unsigned count, inout logic ack);
    if (!level) begin
      count = 0;
      ack   = 1'b0;
    end else if (count >= delay) begin
      ack = 1'b1;
    end else begin
      count = count + 1;
    end
  endtask

  always @(posedge a_clk) begin
    #0.5;
    if (!a_rst_n) begin
      a_iso_cnt = 0;
      a_clr_cnt = 0;
      a_iso_ack = 1'b0;
      a_clr_ack = 1'b0;
    end else begin
      step_ack(a_out.isolate, a_iso_dly, a_iso_cnt, a_iso_ack);
      step_ack(a_out.clear, a_clr_dly, a_clr_cnt, a_clr_ack);
    end
  end

  always @(posedge b_clk) begin
    #0.5;
    if (!b_rst_n) begin
      b_iso_cnt = 0;
      b_clr_cnt = 0;
      b_iso_ack = 1'b0;
      b_clr_ack = 1'b0;
    end else begin
      step_ack(b_out.isolate, b_iso_dly, b_iso_cnt, b_iso_ack);
      step_ack(b_out.clear, b_clr_dly, b_clr_cnt, b_clr_ack);
    end
  end

  // ----------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------

  // b leaves reset up to three cycles after a
  task automatic run_reset(input int unsigned stagger);
    @(posedge a_clk);
    #0.5 a_rst_n = 1'b0;
    @(posedge b_clk);
    #0.5 b_rst_n = 1'b0;
    repeat (5) @(posedge a_clk);
    #0.5 a_rst_n = 1'b1;
    repeat (stagger + 1) @(posedge b_clk);
    #0.5 b_rst_n = 1'b1;
  endtask

  task automatic pulse_a_clear();
    @(posedge a_clk);
    #0.5 a_clear_req = 1'b1;
    @(posedge a_clk);
    #0.5 a_clear_req = 1'b0;
  endtask

  task automatic pulse_b_clear();
    @(posedge b_clk);
    #0.5 b_clear_req = 1'b1;
    @(posedge b_clk);
    #0.5 b_clear_req = 1'b0;
  endtask

  task automatic wait_outputs_active(output logic seen);
    int unsigned cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < 20) begin
      @(posedge a_clk);
      #0.5;
      seen   = a_out.isolate || a_out.clear || b_out.isolate || b_out.clear;
      cycles = cycles + 1;
    end
  endtask

  task automatic wait_outputs_low(output logic done);
    int unsigned cycles;
    done   = 1'b0;
    cycles = 0;
    while (!done && cycles < 200) begin
      @(posedge a_clk);
      #0.5;
      done   = !(a_out.isolate || a_out.clear || b_out.isolate || b_out.clear);
      cycles = cycles + 1;
    end
  endtask

  // ----------------------------------------------------------
  // test sequencing
  // ----------------------------------------------------------

  initial begin
    int unsigned base;
    int unsigned stagger;
    logic [7:0]  trig;
    logic        ok;
    logic        stop;
    a_rst_n     = 1'b0;
    b_rst_n     = 1'b0;
    a_clear_req = 1'b0;
    a_iso_ack   = 1'b0;
    a_clr_ack   = 1'b0;
    b_clear_req = 1'b0;
    b_iso_ack   = 1'b0;
    b_clr_ack   = 1'b0;
    a_iso_dly   = '0;
    a_clr_dly   = '0;
    b_iso_dly   = '0;
    b_clr_dly   = '0;
    void'($urandom(90405));
    stagger = $urandom % 4;
    $display("reset stagger %0d cycles", stagger);
    $readmemh("tb/clear_stimulus.txt", stim_mem);
    base = 0;
    stop = 1'b0;
    while (!stop && base < 80 && !$isunknown(stim_mem[base]) && stim_mem[base] != 8'hff) begin
      trig      = stim_mem[base+1];
      a_iso_dly = stim_mem[base+2];
      a_clr_dly = stim_mem[base+3];
      b_iso_dly = stim_mem[base+4];
      b_clr_dly = stim_mem[base+5];
      u_checker.start_test(stim_mem[base], stim_mem[base+6], stim_mem[base+7],
                           stim_mem[base+8], stim_mem[base+9]);
      ok = 1'b1;
      // trigger 0 is a reset, bit 0 pulses clear on a and bit 1 on b
      if (trig == 8'h00) begin
        run_reset(stagger);
      end else begin
        fork
          if (trig[0]) pulse_a_clear();
          if (trig[1]) pulse_b_clear();
        join
        wait_outputs_active(ok);
      end
      if (ok) wait_outputs_low(ok);
      // a quiet gap catches any late episode
      if (ok) repeat (10) @(posedge a_clk);
      u_checker.finish_test(!ok);
      stop = !ok;
      base = base + 10;
    end
    u_checker.report_totals();
    if (u_checker.error_count == 0 && u_dut.u_half_a.u_sva.fail_count == 0 &&
        u_dut.u_half_b.u_sva.fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/clear_seq_checker.sv */
// checker for the clear-sequence controller
// watches both sides, checks the ordering rules and counts clear episodes per test
`timescale 1ns/100ps
`default_nettype none

module clear_seq_checker (
  input wire logic                     a_clk_i,
  input wire logic                     a_rst_ni,
  input wire clear_seq_pkg::side_in_t  a_in_i,
  input wire clear_seq_pkg::side_out_t a_out_i,
  input wire logic                     b_clk_i,
  input wire logic                     b_rst_ni,
  input wire clear_seq_pkg::side_in_t  b_in_i,
  input wire clear_seq_pkg::side_out_t b_out_i
);

  // index 0 is side a and index 1 is side b everywhere below
  int unsigned episodes [2];
  int unsigned ep_min [2];
  int unsigned ep_max [2];
  logic [1:0]  iso_ack_seen = 2'b00;
  logic [1:0]  clr_ack_seen = 2'b00;
  logic [1:0]  prev_iso     = 2'b00;
  logic [1:0]  prev_clr     = 2'b00;
  int unsigned test_num     = 0;
  int unsigned test_errors  = 0;
  int unsigned error_count  = 0;
  int unsigned tests_passed = 0;
  int unsigned tests_failed = 0;

  // ----------------------------------------------------------
  // error reporting
  // ----------------------------------------------------------

  task automatic report_mismatch(input string name, input int got, input int expected);
    $display("Fail at %0.1f ns: %s = %0d, expected %0d", $realtime, name, got, expected);
    test_errors = test_errors + 1;
    error_count = error_count + 1;
  endtask

  task automatic report_violation(input string what);
    $display("Error at %0.1f ns: %s", $realtime, what);
    test_errors = test_errors + 1;
    error_count = error_count + 1;
  endtask

  // ----------------------------------------------------------
  // sequence rules, evaluated once per cycle on each side
  // ----------------------------------------------------------

  task automatic check_side(input int s, input logic rst_n,
                            input clear_seq_pkg::side_in_t in_v,
                            input clear_seq_pkg::side_out_t out_v);
    string name;
    int    o;
    name = (s == 0) ? "a" : "b";
    o    = 1 - s;
    if (!rst_n) begin
      if (out_v.clear) report_mismatch({name, "_out_o.clear"}, 1, 0);
    end else begin
      if (out_v.clear && !out_v.isolate) report_mismatch({name, "_out_o.isolate"}, 0, 1);
      if (out_v.clear && !prev_clr[s]) begin
        episodes[s] = episodes[s] + 1;
        if (!prev_iso[s]) begin
          report_violation($sformatf("%s clear rose in the cycle its isolate rose", name));
        end
        // a clear on one side always needs the far side to have isolated first
        if (!iso_ack_seen[o]) begin
          report_violation($sformatf("%s clear rose before the other side acknowledged isolate",
                                     name));
        end
      end
      // isolate may only end once both circuits have confirmed their clear
      if (prev_iso[s] && !out_v.isolate && !(clr_ack_seen[0] && clr_ack_seen[1])) begin
        report_violation($sformatf("%s isolate fell before both clear acks were seen", name));
      end
      if (in_v.isolate_ack) iso_ack_seen[s] = 1'b1;
      if (in_v.clear_ack) clr_ack_seen[s] = 1'b1;
    end
    prev_iso[s] = out_v.isolate;
    prev_clr[s] = out_v.clear;
  endtask

  // sampled mid-cycle, where outputs and driven inputs are both stable
  always @(negedge a_clk_i) check_side(0, a_rst_ni, a_in_i, a_out_i);
  always @(negedge b_clk_i) check_side(1, b_rst_ni, b_in_i, b_out_i);

  // ----------------------------------------------------------
  // test bookkeeping
  // ----------------------------------------------------------

  task automatic start_test(input logic [7:0] num, input logic [7:0] a_min,
                            input logic [7:0] a_max, input logic [7:0] b_min,
                            input logic [7:0] b_max);
    test_num     = num;
    test_errors  = 0;
    episodes[0]  = 0;
    episodes[1]  = 0;
    ep_min[0]    = a_min;
    ep_max[0]    = a_max;
    ep_min[1]    = b_min;
    ep_max[1]    = b_max;
    iso_ack_seen = 2'b00;
    clr_ack_seen = 2'b00;
  endtask

  task automatic finish_test(input logic timed_out);
    if (timed_out) begin
      report_violation($sformatf("test %0d timed out, the outputs did not complete a sequence",
                                 test_num));
    end
    for (int s = 0; s < 2; s++) begin
      if (episodes[s] < ep_min[s] || episodes[s] > ep_max[s]) begin
        $display("Fail at %0.1f ns: %s_out_o.clear episodes = %0d, expected %0d to %0d",
                 $realtime, (s == 0) ? "a" : "b", episodes[s], ep_min[s], ep_max[s]);
        test_errors = test_errors + 1;
        error_count = error_count + 1;
      end
    end
    if (test_errors == 0) begin
      tests_passed = tests_passed + 1;
      $display("test %0d passed, clear episodes a %0d b %0d", test_num, episodes[0], episodes[1]);
    end else begin
      tests_failed = tests_failed + 1;
      $display("test %0d failed with %0d errors", test_num, test_errors);
    end
  endtask

  task automatic report_totals();
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             tests_passed + tests_failed, tests_passed, tests_failed, error_count);
  endtask

endmodule

`default_nettype wire

/* tb/clear_seq_sva.sv */
// ordering assertions for one side of the clear-sequence controller
// bound into every clear_ctrl_half instance
`timescale 1ns/100ps
`default_nettype none

module clear_seq_sva (
  input wire logic                     clk_i,
  input wire logic                     rst_ni,
  input wire clear_seq_pkg::side_out_t side_out_i
);

  // number of failed assertions in this half
  int unsigned fail_count = 0;

  // the controlled circuit must never see clear without isolate around it
  clear_inside_isolate: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    side_out_i.clear |-> side_out_i.isolate
  ) else begin
    $error("clear is high while isolate is low");
    fail_count = fail_count + 1;
  end

  // isolate has to settle for at least one cycle before clear follows
  clear_after_isolate_rise: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(side_out_i.isolate) |-> !side_out_i.clear
  ) else begin
    $error("clear is high in the cycle in which isolate rises");
    fail_count = fail_count + 1;
  end

endmodule

bind clear_ctrl_half clear_seq_sva u_sva (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .side_out_i (side_o)
);

`default_nettype wire

/* rtl/cdc_clear_ctrl.sv */
// top of the clear-sequence controller
// two mirrored halves in their own clock domains, joined by two phase links
`timescale 1ns/100ps
`default_nettype none

module cdc_clear_ctrl (
  input  wire logic                    a_clk_i,
  input  wire logic                    a_rst_ni,
  input  wire clear_seq_pkg::side_in_t a_in_i,
  output clear_seq_pkg::side_out_t     a_out_o,
  input  wire logic                    b_clk_i,
  input  wire logic                    b_rst_ni,
  input  wire clear_seq_pkg::side_in_t b_in_i,
  output clear_seq_pkg::side_out_t     b_out_o
);

  // phases from a to b, and the ack that b returns for them
  clear_seq_pkg::phase_link_t a2b;
  logic                       ack_b2a;
  // phases from b to a, and the ack that a returns for them
  clear_seq_pkg::phase_link_t b2a;
  logic                       ack_a2b;

  clear_ctrl_half u_half_a (
    .clk_i      (a_clk_i),
    .rst_ni     (a_rst_ni),
    .side_i     (a_in_i),
    .side_o     (a_out_o),
    .link_o     (a2b),
    .link_ack_i (ack_b2a),
    .link_i     (b2a),
    .link_ack_o (ack_a2b)
  );

  clear_ctrl_half u_half_b (
    .clk_i      (b_clk_i),
    .rst_ni     (b_rst_ni),
    .side_i     (b_in_i),
    .side_o     (b_out_o),
    .link_o     (b2a),
    .link_ack_i (ack_a2b),
    .link_i     (a2b),
    .link_ack_o (ack_b2a)
  );

endmodule

`default_nettype wire

/* rtl/clear_ctrl_half.sv */
// one side of the clear-sequence controller
// local initiator, remote-phase receiver and both crossing ends
`timescale 1ns/100ps
`default_nettype none

module clear_ctrl_half (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire clear_seq_pkg::side_in_t    side_i,
  output clear_seq_pkg::side_out_t        side_o,
  output clear_seq_pkg::phase_link_t      link_o,
  input  wire logic                       link_ack_i,
  input  wire clear_seq_pkg::phase_link_t link_i,
  output logic                            link_ack_o
);

  clear_seq_pkg::clear_phase_e init_phase;
  logic                        init_valid;
  logic                        init_ready;
  logic                        init_isolate;
  logic                        init_clear;
  clear_seq_pkg::clear_phase_e rx_phase;
  logic                        rx_valid;
  logic                        rx_accept;
  logic                        rx_isolate;
  logic                        rx_clear;

  // ----------------------------------------------------------
  // outgoing path
  // ----------------------------------------------------------

  clear_initiator u_initiator (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (side_i.clear),
    .isolate_ack_i (side_i.isolate_ack),
    .clear_ack_i   (side_i.clear_ack),
    .phase_o       (init_phase),
    .phase_valid_o (init_valid),
    .phase_ready_i (init_ready),
    .isolate_o     (init_isolate),
    .clear_o       (init_clear)
  );

  phase_link_src u_link_src (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .phase_i (init_phase),
    .valid_i (init_valid),
    .ready_o (init_ready),
    .link_o  (link_o),
    .ack_i   (link_ack_i)
  );

  // ----------------------------------------------------------
  // incoming path
  // ----------------------------------------------------------

  phase_link_dst u_link_dst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .link_i   (link_i),
    .phase_o  (rx_phase),
    .valid_o  (rx_valid),
    .accept_i (rx_accept),
    .ack_o    (link_ack_o)
  );

  clear_receiver u_receiver (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .phase_i        (rx_phase),
    .phase_valid_i  (rx_valid),
    .phase_accept_o (rx_accept),
    .isolate_ack_i  (side_i.isolate_ack),
    .clear_ack_i    (side_i.clear_ack),
    .isolate_o      (rx_isolate),
    .clear_o        (rx_clear)
  );

  // both sequencers may run at once when the two sides trigger together
  // and the OR keeps isolate around every clear of either of them
  assign side_o.isolate = init_isolate | rx_isolate;
  assign side_o.clear   = init_clear | rx_clear;

endmodule

`default_nettype wire

/* rtl/clear_receiver.sv */
// receiver of one side, follows the phases sent by the remote initiator
// and accepts each one once the local circuit has acknowledged it
`timescale 1ns/100ps
`default_nettype none

module clear_receiver (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  input  wire clear_seq_pkg::clear_phase_e phase_i,
  input  wire logic                        phase_valid_i,
  output logic                             phase_accept_o,
  input  wire logic                        isolate_ack_i,
  input  wire logic                        clear_ack_i,
  output logic                             isolate_o,
  output logic                             clear_o
);

  clear_seq_pkg::clear_phase_e phase_q;
  clear_seq_pkg::clear_phase_e shown_phase;

  // an arriving phase takes effect on the outputs in the same cycle
  assign shown_phase = phase_valid_i ? phase_i : phase_q;

  // ----------------------------------------------------------
  // acceptance
  // ----------------------------------------------------------

  // isolate and clear wait for the matching local ack, the rest pass at once
  always_comb begin
    phase_accept_o = 1'b0;
    if (phase_valid_i) begin
      case (phase_i)
        clear_seq_pkg::PHASE_ISOLATE: phase_accept_o = isolate_ack_i;
        clear_seq_pkg::PHASE_CLEAR:   phase_accept_o = clear_ack_i;
        default:                      phase_accept_o = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= clear_seq_pkg::PHASE_IDLE;
    end else if (phase_valid_i && phase_accept_o) begin
      phase_q <= phase_i;
    end
  end

  // ----------------------------------------------------------
  // output decode
  // ----------------------------------------------------------

  always_comb begin
    isolate_o = 1'b0;
    clear_o   = 1'b0;
    case (shown_phase)
      clear_seq_pkg::PHASE_ISOLATE, clear_seq_pkg::PHASE_POST_CLEAR: begin
        isolate_o = 1'b1;
      end
      clear_seq_pkg::PHASE_CLEAR: begin
        isolate_o = 1'b1;
        clear_o   = 1'b1;
      end
      default: begin
        isolate_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/clear_initiator.sv */
// initiator FSM of one side, steps a local clear sequence through its phases
// and sends each phase across the crossing
`timescale 1ns/100ps
`default_nettype none

module clear_initiator (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   clear_i,
  input  wire logic                   isolate_ack_i,
  input  wire logic                   clear_ack_i,
  output clear_seq_pkg::clear_phase_e phase_o,
  output logic                        phase_valid_o,
  input  wire logic                   phase_ready_i,
  output logic                        isolate_o,
  output logic                        clear_o
);

  typedef enum logic [3:0] {
    IDLE,
    ISOLATE,
    WAIT_ISOLATE_PHASE_ACK,
    WAIT_ISOLATE_ACK,
    CLEAR,
    WAIT_CLEAR_PHASE_ACK,
    WAIT_CLEAR_ACK,
    POST_CLEAR,
    FINISHED
  } init_state_e;

  init_state_e state_d, state_q;

  // ----------------------------------------------------------
  // next state
  // ----------------------------------------------------------

  // isolate and clear are left only with both the local ack and the remote
  // phase ready, and the two may come in either order
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (clear_i) state_d = ISOLATE;
      end
      ISOLATE: begin
        if (phase_ready_i && isolate_ack_i) state_d = CLEAR;
        else if (phase_ready_i) state_d = WAIT_ISOLATE_ACK;
        else if (isolate_ack_i) state_d = WAIT_ISOLATE_PHASE_ACK;
      end
      WAIT_ISOLATE_PHASE_ACK: begin
        if (phase_ready_i) state_d = CLEAR;
      end
      WAIT_ISOLATE_ACK: begin
        if (isolate_ack_i) state_d = CLEAR;
      end
      CLEAR: begin
        if (phase_ready_i && clear_ack_i) state_d = POST_CLEAR;
        else if (phase_ready_i) state_d = WAIT_CLEAR_ACK;
        else if (clear_ack_i) state_d = WAIT_CLEAR_PHASE_ACK;
      end
      WAIT_CLEAR_PHASE_ACK: begin
        if (phase_ready_i) state_d = POST_CLEAR;
      end
      WAIT_CLEAR_ACK: begin
        if (clear_ack_i) state_d = POST_CLEAR;
      end
      // the last two phases only wait for the far side
      POST_CLEAR: begin
        if (phase_ready_i) state_d = FINISHED;
      end
      FINISHED: begin
        if (phase_ready_i) state_d = IDLE;
      end
      default: begin
        state_d = ISOLATE;
      end
    endcase
  end

  // every reset begins a sequence, so the FSM wakes up isolating
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ISOLATE;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------------------------
  // outputs
  // ----------------------------------------------------------

  // isolate covers the whole sequence up to the return to idle
  assign isolate_o = (state_q != IDLE);
  assign clear_o   = state_q inside {CLEAR, WAIT_CLEAR_PHASE_ACK, WAIT_CLEAR_ACK};

  // the wait-for-local-ack states have already had their phase taken
  assign phase_valid_o = state_q inside {ISOLATE, WAIT_ISOLATE_PHASE_ACK, CLEAR,
                                         WAIT_CLEAR_PHASE_ACK, POST_CLEAR, FINISHED};

  always_comb begin
    case (state_q)
      ISOLATE, WAIT_ISOLATE_PHASE_ACK, WAIT_ISOLATE_ACK: phase_o = clear_seq_pkg::PHASE_ISOLATE;
      CLEAR, WAIT_CLEAR_PHASE_ACK, WAIT_CLEAR_ACK:       phase_o = clear_seq_pkg::PHASE_CLEAR;
      POST_CLEAR:                                        phase_o = clear_seq_pkg::PHASE_POST_CLEAR;
      default:                                           phase_o = clear_seq_pkg::PHASE_IDLE;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/phase_link_dst.sv */
// destination end of the four-phase phase crossing
// synchronizes the request, offers the phase and returns the ack
`timescale 1ns/100ps
`default_nettype none

module phase_link_dst (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire clear_seq_pkg::phase_link_t link_i,
  output clear_seq_pkg::clear_phase_e     phase_o,
  output logic                            valid_o,
  input  wire logic                       accept_i,
  output logic                            ack_o
);

  logic [clear_seq_pkg::SYNC_STAGES-1:0] req_sync_q;
  logic                                  req_synced;
  logic                                  ack_d, ack_q;

  // ----------------------------------------------------------
  // request synchronizer
  // ----------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_sync_q <= '0;
    end else begin
      req_sync_q <= {req_sync_q[clear_seq_pkg::SYNC_STAGES-2:0], link_i.req};
    end
  end

  assign req_synced = req_sync_q[clear_seq_pkg::SYNC_STAGES-1]; // last stage only

  // ----------------------------------------------------------
  // acknowledge
  // ----------------------------------------------------------

  // the phase lines are stable whenever the synchronized request is high
  // so they are passed through without their own synchronizer
  assign phase_o = link_i.phase;

  // a request is offered only until it has been acknowledged
  assign valid_o = req_synced && !ack_q;

  // ack rises on acceptance and falls after the request has gone away
  always_comb begin
    ack_d = ack_q;
    if (!ack_q && req_synced && accept_i) begin
      ack_d = 1'b1;
    end else if (ack_q && !req_synced) begin
      ack_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= ack_d;
    end
  end

  assign ack_o = ack_q;

endmodule

`default_nettype wire

/* rtl/phase_link_src.sv */
// source end of the four-phase phase crossing, non-decoupled
// raises the isolate phase on reset so the far side isolates at once
`timescale 1ns/100ps
`default_nettype none

module phase_link_src (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  input  wire clear_seq_pkg::clear_phase_e phase_i,
  input  wire logic                        valid_i,
  output logic                             ready_o,
  output clear_seq_pkg::phase_link_t       link_o,
  input  wire logic                        ack_i
);

  // handshake position of the source
  typedef enum logic [1:0] {
    SRC_IDLE,
    SRC_WAIT_ACK_HIGH,
    SRC_WAIT_ACK_LOW
  } src_state_e;

  src_state_e                               state_d, state_q;
  clear_seq_pkg::phase_link_t               link_d, link_q;
  logic [clear_seq_pkg::SYNC_STAGES-1:0]    ack_sync_q;
  logic                                     ack_synced;

  // ----------------------------------------------------------
  // acknowledge synchronizer
  // ----------------------------------------------------------

  // the last stage is the only one that the FSM looks at
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_sync_q <= '0;
    end else begin
      ack_sync_q <= {ack_sync_q[clear_seq_pkg::SYNC_STAGES-2:0], ack_i};
    end
  end

  assign ack_synced = ack_sync_q[clear_seq_pkg::SYNC_STAGES-1];

  // ----------------------------------------------------------
  // four-phase handshake
  // ----------------------------------------------------------

  always_comb begin
    state_d = state_q;
    link_d  = link_q;
    ready_o = 1'b0;
    case (state_q)
      SRC_IDLE: begin
        // capture the phase and raise the request in one step
        if (valid_i) begin
          link_d.phase = phase_i;
          link_d.req   = 1'b1;
          state_d      = SRC_WAIT_ACK_HIGH;
        end
      end
      SRC_WAIT_ACK_HIGH: begin
        // the far side has taken the phase, so the sender may move on
        if (ack_synced) begin
          ready_o    = 1'b1;
          link_d.req = 1'b0;
          state_d    = SRC_WAIT_ACK_LOW;
        end
      end
      SRC_WAIT_ACK_LOW: begin
        // a new phase is only taken once the ack has returned to zero
        if (!ack_synced) begin
          state_d = SRC_IDLE;
        end
      end
      default: begin
        state_d = SRC_IDLE;
      end
    endcase
  end

  // reset leaves the isolate phase on the wires, waiting for its ack
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= SRC_WAIT_ACK_HIGH;
      link_q.req   <= 1'b1;
      link_q.phase <= clear_seq_pkg::PHASE_ISOLATE;
    end else begin
      state_q <= state_d;
      link_q  <= link_d;
    end
  end

  assign link_o = link_q;

endmodule

`default_nettype wire

/* rtl/clear_seq_pkg.sv */
// clear-sequence controller for a clock-domain crossing
// shared phase encoding, link and side bundles, synchronizer depth
`default_nettype none

package clear_seq_pkg;

  // ----------------------------------------------------------
  // constants
  // ----------------------------------------------------------

  // flip-flop stages on every request and acknowledge that crosses domains
  // keep this below the sync depth of the crossing being cleared
  localparam int unsigned SYNC_STAGES = 2;

  // ----------------------------------------------------------
  // phase of the clear sequence
  // ----------------------------------------------------------

  // the four phases are mirrored on the remote side in lock-step
  // idle drops isolate, post-clear drops clear but keeps isolate
  typedef enum logic [1:0] {
    PHASE_IDLE       = 2'd0,
    PHASE_ISOLATE    = 2'd1,
    PHASE_CLEAR      = 2'd2,
    PHASE_POST_CLEAR = 2'd3
  } clear_phase_e;

  // forward wires of one crossing, the phase is held stable while req is high
  typedef struct packed {
    logic         req;
    clear_phase_e phase;
  } phase_link_t;

  // ----------------------------------------------------------
  // side bundles seen at the top level
  // ----------------------------------------------------------

  // clear is a synchronous request, the acks come from the controlled circuit
  typedef struct packed {
    logic clear;
    logic isolate_ack;
    logic clear_ack;
  } side_in_t;

  typedef struct packed {
    logic isolate;
    logic clear;
  } side_out_t;

endpackage

`default_nettype wire
